/* logic/a2e_pkg.sv */
// Bus typedefs, $C0x0 group numbers and the C8ROM release address
package a2e_pkg;

    // ----------------------------------------------
    // Bus types
    // ----------------------------------------------
    typedef logic [15:0] addr_t;      // CPU address
    typedef logic [7:0]  data_t;      // CPU data byte
    typedef logic [15:0] ram_word_t;  // Low byte main RAM, high byte aux RAM
    typedef logic [7:0]  slot_sel_t;  // One-hot, bit n is slot n
    typedef logic [3:0]  io_group_t;  // Address bits 7..4 inside $C0xx

    // ----------------------------------------------
    // $C0x0 groups handled on the motherboard
    // ----------------------------------------------
    localparam io_group_t IO_KBD    = 4'h0;  // Keyboard data, //e switch writes
    localparam io_group_t IO_C01X   = 4'h1;  // Key strobe clear and status flags
    localparam io_group_t IO_TAPE   = 4'h2;  // Cassette out
    localparam io_group_t IO_SPKR   = 4'h3;
    localparam io_group_t IO_STB    = 4'h4;  // Utility strobe
    localparam io_group_t IO_SWITCH = 4'h5;  // Display switches, annunciators
    localparam io_group_t IO_GAME   = 4'h6;  // Buttons and paddle timers
    localparam io_group_t IO_PDL    = 4'h7;  // Paddle timer trigger
    localparam io_group_t IO_LC     = 4'h8;  // Language card

    // Any access here gives the $C800 space back to the slots
    localparam addr_t C8_RESET_ADDR = 16'hCFFF;

endpackage

/* logic/io_decoder.sv */
// Address decoder: RAM and ROM ranges, $C0xx groups, slot I/O and device selects
`timescale 1ns/1ns

module io_decoder
    import a2e_pkg::*;
(
    input  addr_t     addr,
    input  logic      cxrom,
    input  logic      c3rom,
    input  logic      c8rom,
    output logic      ram_sel,
    output logic      rom_sel,
    output logic      io_group_valid,
    output io_group_t io_group,
    output slot_sel_t io_select,
    output slot_sel_t device_select,
    output logic      io_strobe
);

    assign io_group = addr[7:4];

    always_comb
    begin
        ram_sel        = 1'b0;
        rom_sel        = 1'b0;
        io_group_valid = 1'b0;
        io_select      = '0;
        device_select  = '0;
        io_strobe      = 1'b0;

        if (addr[15:14] != 2'b11)
        begin
            ram_sel = 1'b1;  // $0000-$BFFF
        end
        else if (addr[13:12] != 2'b00)
        begin
            rom_sel = 1'b1;  // $D000-$FFFF
        end
        else
        begin
            case (addr[11:8])
                4'h0:
                begin
                    // Groups 0-8 are on the board, 9-F go to slots 1-7
                    if (!addr[7] || addr[7:4] == IO_LC)
                        io_group_valid = 1'b1;
                    else
                        device_select[addr[6:4]] = 1'b1;
                end
                4'h3:
                begin
                    // Slot 3 firmware is internal unless C3ROM is set
                    if (cxrom || !c3rom)
                        rom_sel = 1'b1;
                    else
                        io_select[3] = 1'b1;
                end
                4'h1, 4'h2, 4'h4, 4'h5, 4'h6, 4'h7:
                begin
                    if (cxrom)
                        rom_sel = 1'b1;
                    else
                        io_select[addr[10:8]] = 1'b1;
                end
                default:
                begin
                    // $C800-$CFFF expansion ROM space
                    if (cxrom || c8rom)
                        rom_sel = 1'b1;
                    else
                        io_strobe = 1'b1;
                end
            endcase
        end
    end

endmodule

/* logic/display_switches.sv */
// Display mode switches, annunciators and speaker flip-flop
`timescale 1ns/1ns

module display_switches
    import a2e_pkg::*;
(
    input  logic       CLK_14M,
    input  logic       reset,
    input  addr_t      addr,
    input  logic       cpu_en,
    input  logic       switch_sel,
    input  logic       spkr_sel,
    output logic       text_mode,
    output logic       mixed_mode,
    output logic       page2,
    output logic       hires_mode,
    output logic [3:0] an,
    output logic       speaker
);

    logic [7:0] soft_sw;  // 0-3 modes, 4-7 annunciators

    always_ff @(posedge CLK_14M or posedge reset)
    begin
        if (reset)
        begin
            soft_sw <= '0;
            speaker <= 1'b0;
        end
        else if (cpu_en)
        begin
            if (switch_sel)
                soft_sw[addr[3:1]] <= addr[0];  // Odd address sets, even clears
            if (spkr_sel)
                speaker <= ~speaker;            // Read or write both click
        end
    end

    assign text_mode  = soft_sw[0];
    assign mixed_mode = soft_sw[1];
    assign page2      = soft_sw[2];
    assign hires_mode = soft_sw[3];
    assign an         = soft_sw[7:4];

endmodule

/* logic/memory_switches.sv */
// //e memory switches at $C00x, C8ROM latch and key strobe acknowledge
`timescale 1ns/1ns

module memory_switches
    import a2e_pkg::*;
(
    input  logic  CLK_14M,
    input  logic  reset,
    input  addr_t addr,
    input  logic  we,
    input  logic  cpu_en,
    input  logic  kbd_sel,
    input  logic  c01x_sel,
    output logic  store80,
    output logic  ramrd,
    output logic  ramwrt,
    output logic  cxrom,
    output logic  altzp,
    output logic  c3rom,
    output logic  col80,
    output logic  altchar,
    output logic  c8rom,
    output logic  read_key
);

    always_ff @(posedge CLK_14M or posedge reset)
    begin
        if (reset)
        begin
            store80  <= 1'b0;
            ramrd    <= 1'b0;
            ramwrt   <= 1'b0;
            cxrom    <= 1'b0;
            altzp    <= 1'b0;
            c3rom    <= 1'b0;
            col80    <= 1'b0;
            altchar  <= 1'b0;
            c8rom    <= 1'b0;
            read_key <= 1'b0;
        end
        else
        begin
            // Read of $C010 or any $C01x write clears the key strobe
            read_key <= cpu_en & c01x_sel & (we | (addr[3:0] == 4'h0));

            if (cpu_en)
            begin
                // ------------------------------------------------
                // Write-only switches, pairs at even/odd address
                // ------------------------------------------------
                if (kbd_sel && we)
                begin
                    case (addr[3:1])
                        3'd0: store80 <= addr[0];
                        3'd1: ramrd   <= addr[0];
                        3'd2: ramwrt  <= addr[0];
                        3'd3: cxrom   <= addr[0];
                        3'd4: altzp   <= addr[0];
                        3'd5: c3rom   <= addr[0];
                        3'd6: col80   <= addr[0];
                        3'd7: altchar <= addr[0];
                    endcase
                end

                // Internal slot 3 ROM claims $C800 until $CFFF is touched
                if (addr[15:8] == 8'hC3 && !c3rom)
                    c8rom <= 1'b1;
                else if (addr == C8_RESET_ADDR)
                    c8rom <= 1'b0;
            end
        end
    end

endmodule

/* logic/language_card.sv */
// Language card bank select, high RAM read and write-enable state machine
`timescale 1ns/1ns

module language_card
    import a2e_pkg::*;
(
    input  logic  CLK_14M,
    input  logic  reset,
    input  addr_t addr,
    input  logic  we,
    input  logic  cpu_en,
    input  logic  lc_sel,
    output logic  bank1,
    output logic  hram_read,
    output logic  hram_read_en,
    output logic  hram_write_en
);

    logic pre_wr;      // Last $C08x access was an odd read
    logic wr_inhibit;  // High RAM write protect
    logic hi_region;   // $D000-$FFFF

    always_ff @(posedge CLK_14M or posedge reset)
    begin
        if (reset)
        begin
            bank1      <= 1'b0;
            hram_read  <= 1'b0;
            pre_wr     <= 1'b0;
            wr_inhibit <= 1'b0;
        end
        else if (cpu_en && lc_sel)
        begin
            bank1     <= addr[3];
            hram_read <= ~(addr[0] ^ addr[1]);  // $C080/3/8/B read RAM
            pre_wr    <= addr[0] & ~we;

            // Two odd reads in a row unlock writes
            if (pre_wr && addr[0] && !we)
                wr_inhibit <= 1'b0;
            else if (!addr[0])
                wr_inhibit <= 1'b1;
        end
    end

    assign hi_region = (addr[15:14] == 2'b11) & (addr[13] | addr[12]);

    assign hram_read_en  = hram_read & hi_region;
    assign hram_write_en = ~wr_inhibit & hi_region;

endmodule

/* logic/bank_mapper.sv */
// Main/aux bank choice, RAM address with $Dxxx bank fold and RAM write enable
`timescale 1ns/1ns

module bank_mapper
    import a2e_pkg::*;
(
    input  addr_t addr,
    input  logic  we,
    input  logic  cpu_en,
    input  logic  ram_sel,
    input  logic  hram_write_en,
    input  logic  bank1,
    input  logic  ramrd,
    input  logic  ramwrt,
    input  logic  altzp,
    input  logic  store80,
    input  logic  page2,
    input  logic  hires_mode,
    output addr_t ram_addr,
    output logic  ram_we,
    output logic  aux
);

    logic rw_aux;  // Plain RAMRD/RAMWRT choice
    logic dxxx;

    assign rw_aux = we ? ramwrt : ramrd;

    always_comb
    begin
        if (addr[15:9] == 7'b0000000 || addr[15:14] == 2'b11)
            aux = altzp;                                  // Zero page, stack, high RAM
        else if (addr[15:10] == 6'b000001)
            aux = store80 ? page2 : rw_aux;               // Text page 1
        else if (addr[15:13] == 3'b001)
            aux = (store80 & hires_mode) ? page2 : rw_aux; // Hires page 1
        else
            aux = rw_aux;
    end

    // ----------------------------------------------
    // Bank 1 of $D000 lives in the unused $C000 RAM
    // ----------------------------------------------
    assign dxxx     = (addr[15:12] == 4'hD);
    assign ram_addr = {addr[15:13], addr[12] & ~(bank1 & dxxx), addr[11:0]};

    assign ram_we = cpu_en & we & (ram_sel | hram_write_en);

endmodule

/* logic/read_mux.sv */
// CPU read data selection with $C01x status flags and gameport bits
`timescale 1ns/1ns

module read_mux
    import a2e_pkg::*;
(
    input  addr_t     addr,
    input  logic      we,
    input  logic      aux,
    input  logic      ram_sel,
    input  logic      hram_read_en,
    input  logic      rom_sel,
    input  logic      io_group_valid,
    input  io_group_t io_group,
    input  ram_word_t ram_do,
    input  data_t     rom_data,
    input  data_t     k,
    input  logic      akd,
    input  data_t     pd,
    input  data_t     gameport,
    input  logic      vbl,
    input  logic      bank1,
    input  logic      hram_read,
    input  logic      store80,
    input  logic      ramrd,
    input  logic      ramwrt,
    input  logic      cxrom,
    input  logic      altzp,
    input  logic      c3rom,
    input  logic      col80,
    input  logic      altchar,
    input  logic      text_mode,
    input  logic      mixed_mode,
    input  logic      page2,
    input  logic      hires_mode,
    output data_t     di
);

    logic [15:0] flags;  // Indexed by addr[3:0] at $C010-$C01F
    logic        mem_read;

    assign flags = {col80, altchar, hires_mode, page2, mixed_mode, text_mode, ~vbl,
                    store80, c3rom, altzp, cxrom, ramwrt, ramrd, hram_read, ~bank1, akd};

    // High RAM shadows ROM on reads only
    assign mem_read = ram_sel | (hram_read_en & ~we);

    always_comb
    begin
        if (mem_read)
            di = aux ? ram_do[15:8] : ram_do[7:0];
        else if (io_group_valid)
        begin
            case (io_group)
                IO_KBD:  di = k;
                IO_C01X: di = {flags[addr[3:0]], k[6:0]};
                IO_GAME: di = {gameport[addr[2:0]], 7'b0000000};
                IO_TAPE, IO_SPKR, IO_STB, IO_SWITCH, IO_PDL, IO_LC:
                    di = '0;                                   // No data on these
                default: di = '0;
            endcase
        end
        else if (rom_sel)
            di = rom_data;
        else
            di = pd;  // Slot cards
    end

endmodule

/* logic/a2e_memory_io.sv */
// Memory and I/O controller top level, decoder and switch blocks wired together
`timescale 1ns/1ns

module a2e_memory_io
    import a2e_pkg::*;
(
    input  logic       CLK_14M,
    input  logic       reset,
    input  addr_t      addr,
    input  logic       we,
    input  logic       cpu_en,
    input  ram_word_t  ram_do,
    input  data_t      rom_data,
    input  data_t      k,
    input  logic       akd,
    input  data_t      pd,
    input  data_t      gameport,
    input  logic       vbl,
    output data_t      di,
    output addr_t      ram_addr,
    output logic       ram_we,
    output logic       aux,
    output logic       read_key,
    output logic [3:0] an,
    output logic       text_mode,
    output logic       mixed_mode,
    output logic       page2,
    output logic       hires_mode,
    output logic       col80,
    output logic       altchar,
    output logic       store80,
    output logic       kbd_strobe,
    output logic       pdl_strobe,
    output slot_sel_t  io_select,
    output slot_sel_t  device_select,
    output logic       io_strobe,
    output logic       speaker
);

    logic      ram_sel, rom_sel, io_group_valid;
    io_group_t io_group;
    logic      cxrom, c3rom, c8rom, ramrd, ramwrt, altzp;
    logic      bank1, hram_read, hram_read_en, hram_write_en;
    logic      kbd_sel, c01x_sel, spkr_sel, switch_sel, lc_sel;

    // ----------------------------------------------
    // Group selects from the $C0x0 decode
    // ----------------------------------------------
    assign kbd_sel    = io_group_valid & (io_group == IO_KBD);
    assign c01x_sel   = io_group_valid & (io_group == IO_C01X);
    assign spkr_sel   = io_group_valid & (io_group == IO_SPKR);
    assign switch_sel = io_group_valid & (io_group == IO_SWITCH);
    assign lc_sel     = io_group_valid & (io_group == IO_LC);
    assign kbd_strobe = io_group_valid & (io_group == IO_STB);
    assign pdl_strobe = io_group_valid & (io_group == IO_PDL);

    io_decoder decoder_i (
        .addr(addr), .cxrom(cxrom), .c3rom(c3rom), .c8rom(c8rom),
        .ram_sel(ram_sel), .rom_sel(rom_sel), .io_group_valid(io_group_valid),
        .io_group(io_group), .io_select(io_select), .device_select(device_select),
        .io_strobe(io_strobe)
    );

    display_switches display_i (
        .CLK_14M(CLK_14M), .reset(reset), .addr(addr), .cpu_en(cpu_en),
        .switch_sel(switch_sel), .spkr_sel(spkr_sel), .text_mode(text_mode),
        .mixed_mode(mixed_mode), .page2(page2), .hires_mode(hires_mode),
        .an(an), .speaker(speaker)
    );

    memory_switches mem_sw_i (
        .CLK_14M(CLK_14M), .reset(reset), .addr(addr), .we(we), .cpu_en(cpu_en),
        .kbd_sel(kbd_sel), .c01x_sel(c01x_sel), .store80(store80), .ramrd(ramrd),
        .ramwrt(ramwrt), .cxrom(cxrom), .altzp(altzp), .c3rom(c3rom), .col80(col80),
        .altchar(altchar), .c8rom(c8rom), .read_key(read_key)
    );

    language_card lc_i (
        .CLK_14M(CLK_14M), .reset(reset), .addr(addr), .we(we), .cpu_en(cpu_en),
        .lc_sel(lc_sel), .bank1(bank1), .hram_read(hram_read),
        .hram_read_en(hram_read_en), .hram_write_en(hram_write_en)
    );

    bank_mapper mapper_i (
        .addr(addr), .we(we), .cpu_en(cpu_en), .ram_sel(ram_sel),
        .hram_write_en(hram_write_en), .bank1(bank1), .ramrd(ramrd), .ramwrt(ramwrt),
        .altzp(altzp), .store80(store80), .page2(page2), .hires_mode(hires_mode),
        .ram_addr(ram_addr), .ram_we(ram_we), .aux(aux)
    );

    read_mux rd_mux_i (
        .addr(addr), .we(we), .aux(aux), .ram_sel(ram_sel), .hram_read_en(hram_read_en),
        .rom_sel(rom_sel), .io_group_valid(io_group_valid), .io_group(io_group),
        .ram_do(ram_do), .rom_data(rom_data), .k(k), .akd(akd), .pd(pd),
        .gameport(gameport), .vbl(vbl), .bank1(bank1), .hram_read(hram_read),
        .store80(store80), .ramrd(ramrd), .ramwrt(ramwrt), .cxrom(cxrom),
        .altzp(altzp), .c3rom(c3rom), .col80(col80), .altchar(altchar),
        .text_mode(text_mode), .mixed_mode(mixed_mode), .page2(page2),
        .hires_mode(hires_mode), .di(di)
    );

endmodule

/* verification/a2e_properties.sv */
// Bound assertions for decode, //e switches, language card, aux banking and display switches
`timescale 1ns/1ns

module a2e_properties
    import a2e_pkg::*;
(
    input logic       CLK_14M,
    input logic       reset,
    input addr_t      addr,
    input logic       we,
    input logic       cpu_en,
    input ram_word_t  ram_do,
    input data_t      rom_data,
    input data_t      k,
    input logic       akd,
    input data_t      pd,
    input logic       vbl,
    input data_t      di,
    input addr_t      ram_addr,
    input logic       ram_we,
    input logic       aux,
    input logic       read_key,
    input logic [3:0] an,
    input logic       text_mode,
    input logic       mixed_mode,
    input logic       page2,
    input logic       hires_mode,
    input logic       col80,
    input logic       altchar,
    input logic       store80,
    input logic       kbd_strobe,
    input logic       pdl_strobe,
    input slot_sel_t  io_select,
    input slot_sel_t  device_select,
    input logic       io_strobe,
    input logic       speaker,
    input logic       cxrom,
    input logic       c3rom,
    input logic       c8rom,
    input logic       ramrd,
    input logic       ramwrt,
    input logic       altzp,
    input logic       bank1,
    input logic       hram_read
);

    int          fail_count = 0;
    addr_t       last_addr;   // Address of the previous clock
    logic        pre_m;       // Odd $C08x read seen
    logic        inh_m;       // Expected high RAM write protect
    logic        aux_exp;
    logic [7:0]  mem_sw;
    logic [7:0]  disp;
    logic [15:0] status;

    task automatic flag(input string msg);
        $error("%s", msg);
        fail_count++;
    endtask

    assign mem_sw = {altchar, col80, c3rom, altzp, cxrom, ramwrt, ramrd, store80};
    assign disp   = {an, hires_mode, page2, mixed_mode, text_mode};
    assign status = {col80, altchar, hires_mode, page2, mixed_mode, text_mode, ~vbl,
                     store80, c3rom, altzp, cxrom, ramwrt, ramrd, hram_read, ~bank1, akd};

    // --------------------------------------------------
    // Reference models for language card and banking
    // --------------------------------------------------
    always_ff @(posedge CLK_14M or posedge reset)
    begin
        if (reset)
        begin
            last_addr <= '0;
            pre_m     <= 1'b0;
            inh_m     <= 1'b0;   // Writes enabled out of reset
        end
        else
        begin
            last_addr <= addr;
            if (cpu_en && addr[15:4] == 12'hC08)
            begin
                pre_m <= addr[0] & ~we;
                if (pre_m && addr[0] && !we)
                    inh_m <= 1'b0;   // Second odd read unlocks
                else if (!addr[0])
                    inh_m <= 1'b1;
            end
        end
    end

    always_comb
    begin
        if (addr[15:9] == 7'd0 || addr[15:14] == 2'b11)
            aux_exp = altzp;
        else if (addr[15:10] == 6'b000001 && store80)
            aux_exp = page2;
        else if (addr[15:13] == 3'b001 && store80 && hires_mode)
            aux_exp = page2;
        else
            aux_exp = we ? ramwrt : ramrd;
    end

    // --------------------------------------------------
    // Decode and ROM selection
    // --------------------------------------------------
    a_rom_read: assert property (@(posedge CLK_14M) disable iff (reset)
        (!we && addr[15:12] >= 4'hD && !hram_read) |-> di == rom_data)
        else flag($sformatf("ERROR di=%h expected %h", $sampled(di), $sampled(rom_data)));

    a_slot6: assert property (@(posedge CLK_14M) disable iff (reset)
        (addr[15:8] == 8'hC6) |-> io_select == (cxrom ? 8'h00 : 8'h40))
        else flag($sformatf("ERROR io_select=%h with cxrom=%h", $sampled(io_select),
                            $sampled(cxrom)));

    a_slot6_data: assert property (@(posedge CLK_14M) disable iff (reset)
        (!we && addr[15:8] == 8'hC6) |-> di == (cxrom ? rom_data : pd))
        else flag($sformatf("ERROR di=%h expected %h", $sampled(di),
                            $sampled(cxrom ? rom_data : pd)));

    a_c8_space: assert property (@(posedge CLK_14M) disable iff (reset)
        (addr[15:11] == 5'b11001) |-> io_strobe == (!cxrom && !c8rom))
        else flag($sformatf("ERROR io_strobe=%h expected %h", $sampled(io_strobe),
                            $sampled(!cxrom && !c8rom)));

    a_c8rom_set: assert property (@(posedge CLK_14M) disable iff (reset)
        (cpu_en && addr[15:8] == 8'hC3 && !c3rom) |=> c8rom)
        else flag($sformatf("ERROR c8rom=%h expected 1", $sampled(c8rom)));

    a_c8rom_clr: assert property (@(posedge CLK_14M) disable iff (reset)
        (cpu_en && addr == C8_RESET_ADDR) |=> !c8rom)
        else flag($sformatf("ERROR c8rom=%h expected 0", $sampled(c8rom)));

    a_dev_sel: assert property (@(posedge CLK_14M) disable iff (reset)
        (addr[15:8] == 8'hC0 && addr[7] && addr[6:4] != 3'd0)
        |-> device_select == (8'd1 << addr[6:4]))
        else flag($sformatf("ERROR device_select=%h expected %h", $sampled(device_select),
                            $sampled(8'd1 << addr[6:4])));

    a_strobes: assert property (@(posedge CLK_14M) disable iff (reset)
        kbd_strobe == (addr[15:4] == 12'hC04) && pdl_strobe == (addr[15:4] == 12'hC07))
        else flag($sformatf("ERROR kbd_strobe=%h pdl_strobe=%h at addr=%h",
                            $sampled(kbd_strobe), $sampled(pdl_strobe), $sampled(addr)));

    // --------------------------------------------------
    // //e switches, status flags and key strobe
    // --------------------------------------------------
    a_mem_sw: assert property (@(posedge CLK_14M) disable iff (reset)
        (cpu_en && we && addr[15:4] == 12'hC00) |=> mem_sw[last_addr[3:1]] == last_addr[0])
        else flag($sformatf("ERROR mem_sw=%h after write to %h", $sampled(mem_sw),
                            $sampled(last_addr)));

    a_status: assert property (@(posedge CLK_14M) disable iff (reset)
        (!we && addr[15:4] == 12'hC01) |-> di == {status[addr[3:0]], k[6:0]})
        else flag($sformatf("ERROR di=%h expected %h", $sampled(di),
                            $sampled({status[addr[3:0]], k[6:0]})));

    a_read_key: assert property (@(posedge CLK_14M) disable iff (reset)
        (cpu_en && addr[15:4] == 12'hC01 && (we || addr[3:0] == 4'h0))
        |=> read_key ##1 !read_key)
        else flag("read_key was not a single clock pulse after a key strobe access");

    // --------------------------------------------------
    // Language card and RAM banking
    // --------------------------------------------------
    a_lc_regs: assert property (@(posedge CLK_14M) disable iff (reset)
        (cpu_en && addr[15:4] == 12'hC08)
        |=> bank1 == last_addr[3] && hram_read == (last_addr[0] ~^ last_addr[1]))
        else flag($sformatf("ERROR bank1=%h hram_read=%h after access to %h",
                            $sampled(bank1), $sampled(hram_read), $sampled(last_addr)));

    a_ram_we: assert property (@(posedge CLK_14M) disable iff (reset)
        ram_we == (cpu_en && we && (addr[15:14] != 2'b11 || (addr[15:12] >= 4'hD && !inh_m))))
        else flag($sformatf("ERROR ram_we=%h at addr=%h inhibit=%h", $sampled(ram_we),
                            $sampled(addr), $sampled(inh_m)));

    a_ram_addr: assert property (@(posedge CLK_14M) disable iff (reset)
        ram_addr == ((addr[15:12] == 4'hD && bank1) ? {4'hC, addr[11:0]} : addr))
        else flag($sformatf("ERROR ram_addr=%h for addr=%h", $sampled(ram_addr),
                            $sampled(addr)));

    a_aux: assert property (@(posedge CLK_14M) disable iff (reset) aux == aux_exp)
        else flag($sformatf("ERROR aux=%h expected %h", $sampled(aux), $sampled(aux_exp)));

    a_ram_data: assert property (@(posedge CLK_14M) disable iff (reset)
        (!we && (addr[15:14] != 2'b11 || (addr[15:12] >= 4'hD && hram_read)))
        |-> di == (aux_exp ? ram_do[15:8] : ram_do[7:0]))
        else flag($sformatf("ERROR di=%h ram_do=%h aux=%h", $sampled(di), $sampled(ram_do),
                            $sampled(aux_exp)));

    // --------------------------------------------------
    // Display switches and speaker
    // --------------------------------------------------
    a_disp_sw: assert property (@(posedge CLK_14M) disable iff (reset)
        (cpu_en && addr[15:4] == 12'hC05) |=> disp[last_addr[3:1]] == last_addr[0])
        else flag($sformatf("ERROR disp=%h after access to %h", $sampled(disp),
                            $sampled(last_addr)));

    a_speaker: assert property (@(posedge CLK_14M) disable iff (reset)
        (cpu_en && addr[15:4] == 12'hC03) |=> speaker != $past(speaker))
        else flag($sformatf("ERROR speaker=%h did not toggle", $sampled(speaker)));

endmodule

/* verification/tb_a2e_memory_io.sv */
// Testbench top with clock, reset, CPU bus-cycle tasks, random bus data and directed sequence
`timescale 1ns/1ns

module tb_a2e_memory_io;
    import a2e_pkg::*;

    logic       CLK_14M;
    logic       reset;
    addr_t      addr;
    logic       we;
    logic       cpu_en;
    ram_word_t  ram_do;
    data_t      rom_data;
    data_t      k;
    logic       akd;
    data_t      pd;
    data_t      gameport;
    logic       vbl;
    data_t      di;
    addr_t      ram_addr;
    logic       ram_we;
    logic       aux;
    logic       read_key;
    logic [3:0] an;
    logic       text_mode;
    logic       mixed_mode;
    logic       page2;
    logic       hires_mode;
    logic       col80;
    logic       altchar;
    logic       store80;
    logic       kbd_strobe;
    logic       pdl_strobe;
    slot_sel_t  io_select;
    slot_sel_t  device_select;
    logic       io_strobe;
    logic       speaker;

    logic [31:0] lcg_state = 32'd13759;

    a2e_memory_io dut_i (.*);

    bind a2e_memory_io a2e_properties props_i (.*);

    initial
    begin
        CLK_14M = 1'b0;
        forever #5 CLK_14M = ~CLK_14M;
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic stop_with_failure(input string reason);
        $display("Run stopped: %s", reason);
        $display("FAIL: see errors above");
        $fatal(1, "simulation aborted");
    endtask

    task automatic randomize_bus_data();
        logic [31:0] r;
        r        = next_random();
        ram_do   = r[31:16];
        rom_data = r[15:8];
        r        = next_random();
        k        = r[31:24];
        pd       = r[23:16];
        akd      = r[15];
    endtask

    // --------------------------------------------------
    // Bus cycle that starts and ends on a falling edge
    // --------------------------------------------------
    task automatic bus_cycle(input addr_t a, input logic w);
        randomize_bus_data();
        addr   = a;
        we     = w;
        cpu_en = 1'b1;
        @(negedge CLK_14M);
        cpu_en = 1'b0;   // Address held one more clock
        @(negedge CLK_14M);
    endtask

    task automatic cpu_read(input addr_t a);
        bus_cycle(a, 1'b0);
    endtask

    task automatic cpu_write(input addr_t a);
        bus_cycle(a, 1'b1);
    endtask

    // $C010 read, then poll for the key acknowledge
    task automatic read_key_strobe();
        int cycles;
        randomize_bus_data();
        addr   = 16'hC010;
        we     = 1'b0;
        cpu_en = 1'b1;
        @(negedge CLK_14M);
        cpu_en = 1'b0;
        cycles = 0;
        while (!read_key && cycles < 8)
        begin
            @(negedge CLK_14M);
            cycles++;
        end
        if (!read_key)
            stop_with_failure("read_key never pulsed after the $C010 read");
        @(negedge CLK_14M);
    endtask

    always @(posedge CLK_14M)
    begin
        if (dut_i.props_i.fail_count != 0)
            stop_with_failure("an assertion failed");
    end

    initial
    begin
        reset    = 1'b1;
        addr     = '0;
        we       = 1'b0;
        cpu_en   = 1'b0;
        ram_do   = '0;
        rom_data = '0;
        k        = '0;
        akd      = 1'b0;
        pd       = '0;
        gameport = 8'h5A;
        vbl      = 1'b0;
        repeat (4) @(negedge CLK_14M);
        reset = 1'b0;

        // Decode and ROM selection
        cpu_read(16'hF000);
        cpu_read(16'hC600);
        cpu_read(16'hC800);    // Slot expansion strobe
        cpu_read(16'hC300);    // Claims $C800 for internal ROM
        cpu_read(16'hC800);
        cpu_read(16'hCFFF);
        cpu_write(16'hC007);   // CXROM on
        cpu_read(16'hC600);
        cpu_read(16'hC800);
        cpu_write(16'hC006);
        cpu_read(16'hC0E0);
        cpu_read(16'hC040);    // Utility strobe
        cpu_read(16'hC070);    // Paddle trigger

        // //e switches and status readback
        cpu_write(16'hC003);
        cpu_read(16'hC013);
        cpu_write(16'hC002);
        cpu_read(16'hC013);
        read_key_strobe();

        // Language card
        cpu_read(16'hC082);    // Write protect, ROM read
        cpu_write(16'hE000);
        cpu_read(16'hC08B);
        cpu_read(16'hC08B);    // Second odd read unlocks writes
        cpu_write(16'hD123);
        cpu_read(16'hF000);

        // Aux banking
        cpu_write(16'hC003);
        cpu_read(16'h2000);
        cpu_write(16'hC001);   // STORE80
        cpu_write(16'hC055);   // PAGE2
        cpu_read(16'h0400);
        cpu_write(16'hC002);
        cpu_read(16'h0400);
        cpu_write(16'hC009);   // ALTZP
        cpu_read(16'h0100);

        // Display switches and speaker
        cpu_read(16'hC051);
        cpu_read(16'hC05F);
        cpu_read(16'hC030);
        cpu_write(16'hC030);

        repeat (2) @(negedge CLK_14M);
        if (dut_i.props_i.fail_count != 0)
            stop_with_failure("assertion failures at end of run");
        else
        begin
            $display("PASS: all tests");
            $finish;
        end
    end

endmodule

/* vlog.f */
logic/a2e_pkg.sv
logic/io_decoder.sv
logic/display_switches.sv
logic/memory_switches.sv
logic/language_card.sv
logic/bank_mapper.sv
logic/read_mux.sv
logic/a2e_memory_io.sv
verification/a2e_properties.sv
verification/tb_a2e_memory_io.sv
